// File: verilog/cavlc_defs.svh
//------------------------------------------------------------
// Width and count macros for the CAVLC residual level coder.
// Include this file in every RTL file and in the testbench.
//------------------------------------------------------------
`ifndef CAVLC_DEFS_SVH
`define CAVLC_DEFS_SVH

// block layout
`define CAVLC_COEFF_W        16   // one coefficient
`define CAVLC_BLK_N          16   // coefficients per 4x4 block
`define CAVLC_BEATS          8    // two coefficients per beat
`define CAVLC_BLK_W          256  // whole block word

// level codes
`define CAVLC_CODE_W         28   // 16 prefix bits plus 12 suffix bits
`define CAVLC_LEN_W          5
`define CAVLC_MAX_T1         3
`define CAVLC_ESC_PREFIX     15
`define CAVLC_ESC_SUFFIX_W   12
`define CAVLC_MAX_SUFFIX_LEN 6

// packer
`define CAVLC_BITCNT_W       9    // code bits of one block

`endif

// File: verilog/cavlc_coeff_pkg.sv
//------------------------------------------------------------
// Coefficient block layout. A block word is read either as
// sixteen signed coefficients or as eight coefficient pairs.
// Index 0 is the lowest frequency in zig-zag order.
//------------------------------------------------------------
`include "cavlc_defs.svh"

package cavlc_coeff_pkg;

	// ------------------------------------------------------
	// one 256-bit block, two views of the same bits
	// ------------------------------------------------------
	typedef union packed {
		// coef[k] is zig-zag position k, signed 16 bit
		logic signed [`CAVLC_BLK_N-1:0][`CAVLC_COEFF_W-1:0] coef;
		// pair[p] holds coef[2p+1] in the upper half
		logic [`CAVLC_BEATS-1:0][`CAVLC_BLK_W/`CAVLC_BEATS-1:0] pair;
	} cavlc_block_u;

endpackage

// File: verilog/cavlc_code_pkg.sv
//------------------------------------------------------------
// Level code rules shared by the level coder and the model
// in the testbench: level to level code, the prefix/suffix
// split with both escape forms, and suffix length adaptation.
//------------------------------------------------------------
`include "cavlc_defs.svh"

package cavlc_code_pkg;

	// level code, adj set for the first level after fewer than 3 T1s
	function automatic logic [15:0] level_code_of(
		input logic signed [`CAVLC_COEFF_W-1:0] level,
		input logic adj);
		logic [15:0] code;
		if (level > 0)
			code = 16'(2 * level - 2);
		else
			code = 16'(-2 * level - 1);
		if (adj)
			code = code - 16'd2;
		return code;
	endfunction

	// split a level code, len is the whole code length
	function automatic void level_prefix_suffix(
		input  logic [15:0] code,
		input  logic [2:0] sfx_len,
		output logic [4:0] prefix,
		output logic [`CAVLC_ESC_SUFFIX_W-1:0] suffix,
		output logic [`CAVLC_LEN_W-1:0] len);
		logic [15:0] hi;
		hi = code >> sfx_len;
		if (sfx_len == 3'd0) begin
			if (code < 16'd14) begin
				prefix = code[4:0];
				suffix = '0;
				len = 5'(code + 16'd1);
			end else if (code < 16'd30) begin
				prefix = 5'd14;             // 4-bit suffix
				suffix = 12'(code - 16'd14);
				len = 5'd19;
			end else begin
				prefix = 5'(`CAVLC_ESC_PREFIX);
				suffix = 12'(code - 16'd30);
				len = 5'(`CAVLC_ESC_PREFIX + 1 + `CAVLC_ESC_SUFFIX_W);
			end
		end else if (hi < 16'(`CAVLC_ESC_PREFIX)) begin
			prefix = hi[4:0];
			suffix = 12'(code & ((16'd1 << sfx_len) - 16'd1));
			len = 5'(hi + 16'd1 + 16'(sfx_len));
		end else begin
			prefix = 5'(`CAVLC_ESC_PREFIX);
			suffix = 12'(code - (16'(`CAVLC_ESC_PREFIX) << sfx_len));
			len = 5'(`CAVLC_ESC_PREFIX + 1 + `CAVLC_ESC_SUFFIX_W);
		end
	endfunction

	// adaptation after each coded level
	function automatic logic [2:0] next_suffix_len(
		input logic [2:0] sfx_len,
		input logic [15:0] mag);
		logic [2:0] sl;
		sl = (sfx_len == 3'd0) ? 3'd1 : sfx_len;
		if (mag > (16'd3 << (sl - 3'd1)) && sl < 3'(`CAVLC_MAX_SUFFIX_LEN))
			sl = sl + 3'd1;
		return sl;
	endfunction

endpackage

// File: verilog/cavlc_block_scan.sv
//------------------------------------------------------------
// First stage. Captures a block on an accepted start, walks
// it two coefficients per beat from the highest frequency and
// builds total coeff, trailing ones with signs, total zeros
// and the nonzero levels in reverse scan order. The result is
// held until the level coder takes it.
//------------------------------------------------------------
`include "cavlc_defs.svh"

module cavlc_block_scan import cavlc_coeff_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start_i,
	input  cavlc_block_u block_i,
	input  logic         take_i,
	output logic         busy_o,
	output logic         valid_o,
	output logic [4:0]   total_coeff_o,
	output logic [1:0]   trailing_ones_o,
	output logic [2:0]   t1_signs_o,
	output logic [3:0]   total_zeros_o,
	output cavlc_block_u levels_o
);

	logic         run_q;
	logic         valid_q;
	logic [2:0]   beat_q;
	logic         accept;
	logic         last_beat;
	cavlc_block_u blk_q;

	// running statistics
	logic [4:0]   tc_q, tc_d;
	logic [1:0]   t1_q, t1_d;
	logic         t1_done_q, t1_done_d;  // a non-T1 level was seen
	logic [2:0]   signs_q, signs_d;
	logic [3:0]   tz_q, tz_d;
	logic         seen_q, seen_d;        // first nonzero passed
	cavlc_block_u list_q, list_d;

	logic [`CAVLC_BLK_W/`CAVLC_BEATS-1:0] pair_w;
	logic signed [`CAVLC_COEFF_W-1:0]     coef;

	assign accept    = start_i & ~busy_o;
	assign last_beat = run_q && (beat_q == 3'(`CAVLC_BEATS - 1));

	// ------------------------------------------------------
	// one beat: upper coefficient of the pair first
	// ------------------------------------------------------
	always_comb begin
		tc_d      = tc_q;
		t1_d      = t1_q;
		t1_done_d = t1_done_q;
		signs_d   = signs_q;
		tz_d      = tz_q;
		seen_d    = seen_q;
		list_d    = list_q;
		pair_w    = blk_q.pair[3'(`CAVLC_BEATS - 1) - beat_q];
		for (int k = 1; k >= 0; k--) begin
			coef = $signed(pair_w[k*`CAVLC_COEFF_W +: `CAVLC_COEFF_W]);
			if (coef != '0) begin
				list_d.coef[tc_d[3:0]] = coef;   // next free slot
				tc_d   = tc_d + 5'd1;
				seen_d = 1'b1;
				if (!t1_done_d && (coef == 16'sd1 || coef == -16'sd1) &&
						t1_d < 2'(`CAVLC_MAX_T1)) begin
					t1_d    = t1_d + 2'd1;
					signs_d = {signs_d[1:0], coef[`CAVLC_COEFF_W-1]};
				end else begin
					t1_done_d = 1'b1;
				end
			end else if (seen_d) begin
				tz_d = tz_d + 4'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q     <= 1'b0;
			valid_q   <= 1'b0;
			beat_q    <= '0;
			tc_q      <= '0;
			t1_q      <= '0;
			t1_done_q <= 1'b0;
			signs_q   <= '0;
			tz_q      <= '0;
			seen_q    <= 1'b0;
		end else if (accept) begin
			run_q     <= 1'b1;
			beat_q    <= '0;
			tc_q      <= '0;
			t1_q      <= '0;
			t1_done_q <= 1'b0;
			signs_q   <= '0;
			tz_q      <= '0;
			seen_q    <= 1'b0;
		end else if (run_q) begin
			beat_q    <= beat_q + 3'd1;
			tc_q      <= tc_d;
			t1_q      <= t1_d;
			t1_done_q <= t1_done_d;
			signs_q   <= signs_d;
			tz_q      <= tz_d;
			seen_q    <= seen_d;
			if (last_beat) begin
				run_q   <= 1'b0;
				valid_q <= 1'b1;   // result ready 9 cycles after start
			end
		end else if (take_i) begin
			valid_q <= 1'b0;
		end
	end

	// block word and level list
	always_ff @(posedge clk) begin
		if (accept)
			blk_q <= block_i;
		if (run_q)
			list_q <= list_d;
	end

	assign busy_o          = run_q | valid_q;
	assign valid_o         = valid_q;
	assign total_coeff_o   = tc_q;
	assign trailing_ones_o = t1_q;
	assign t1_signs_o      = signs_q;
	assign total_zeros_o   = tz_q;
	assign levels_o        = list_q;

endmodule

// File: verilog/cavlc_level_coder.sv
//------------------------------------------------------------
// Second stage. Takes a scan result when idle, then emits the
// trailing-one sign bits as one code followed by one level
// code per cycle. Holds back while the packer is full. An
// empty block gives a single zero-length last code.
//------------------------------------------------------------
`include "cavlc_defs.svh"

module cavlc_level_coder import cavlc_coeff_pkg::*, cavlc_code_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     valid_i,
	output logic                     take_o,
	input  logic [4:0]               total_coeff_i,
	input  logic [1:0]               trailing_ones_i,
	input  logic [2:0]               t1_signs_i,
	input  cavlc_block_u             levels_i,
	input  logic                     packer_full_i,
	output logic [`CAVLC_CODE_W-1:0] code_bits_o,
	output logic [`CAVLC_LEN_W-1:0]  code_len_o,
	output logic                     code_we_o,
	output logic                     code_last_o
);

	logic         active_q;
	logic         sign_q;     // sign code still to send
	logic         first_q;    // next level is the first non-T1 one
	logic [3:0]   idx_q;
	logic [2:0]   sfx_q;
	logic [4:0]   tc_q;
	logic [1:0]   t1_q;
	logic [2:0]   signs_q;
	cavlc_block_u lv_q;

	logic signed [`CAVLC_COEFF_W-1:0] lvl;
	logic [15:0]                      mag;
	logic [15:0]                      lcode;
	logic [4:0]                       pfx;
	logic [`CAVLC_ESC_SUFFIX_W-1:0]   sfx;
	logic [`CAVLC_LEN_W-1:0]          lvl_len;
	logic [`CAVLC_LEN_W-1:0]          sw;
	logic [`CAVLC_CODE_W-1:0]         lvl_bits;

	assign take_o = valid_i & ~active_q;

	// ------------------------------------------------------
	// current level code
	// ------------------------------------------------------
	always_comb begin
		lvl   = $signed(lv_q.coef[idx_q]);
		mag   = lvl[`CAVLC_COEFF_W-1] ? 16'(-lvl) : 16'(lvl);
		lcode = level_code_of(lvl, first_q && (t1_q < 2'(`CAVLC_MAX_T1)));
		level_prefix_suffix(lcode, sfx_q, pfx, sfx, lvl_len);
		sw       = lvl_len - pfx - 5'd1;      // suffix width
		lvl_bits = (`CAVLC_CODE_W'(1) << sw) | `CAVLC_CODE_W'(sfx);
	end

	always_comb begin
		if (tc_q == 5'd0) begin
			code_bits_o = '0;                 // empty block marker
			code_len_o  = '0;
			code_last_o = 1'b1;
		end else if (sign_q) begin
			code_bits_o = `CAVLC_CODE_W'(signs_q);
			code_len_o  = `CAVLC_LEN_W'(t1_q);
			code_last_o = (tc_q == 5'(t1_q));
		end else begin
			code_bits_o = lvl_bits;
			code_len_o  = lvl_len;
			code_last_o = (5'(idx_q) == tc_q - 5'd1);
		end
	end

	assign code_we_o = active_q & ~packer_full_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			sign_q   <= 1'b0;
			first_q  <= 1'b0;
			idx_q    <= '0;
			sfx_q    <= '0;
			tc_q     <= '0;
			t1_q     <= '0;
			signs_q  <= '0;
		end else if (take_o) begin
			active_q <= 1'b1;
			sign_q   <= (trailing_ones_i != 2'd0);
			first_q  <= 1'b1;
			idx_q    <= 4'(trailing_ones_i);   // skip the T1s
			tc_q     <= total_coeff_i;
			t1_q     <= trailing_ones_i;
			signs_q  <= t1_signs_i;
			// initial suffix length
			if (total_coeff_i > 5'd10 && trailing_ones_i < 2'(`CAVLC_MAX_T1))
				sfx_q <= 3'd1;
			else
				sfx_q <= 3'd0;
		end else if (code_we_o) begin
			if (code_last_o)
				active_q <= 1'b0;
			if (sign_q) begin
				sign_q <= 1'b0;
			end else if (tc_q != 5'd0) begin
				idx_q   <= idx_q + 4'd1;
				first_q <= 1'b0;
				sfx_q   <= next_suffix_len(sfx_q, mag);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_o)
			lv_q <= levels_i;
	end

endmodule

// File: verilog/cavlc_bit_packer.sv
//------------------------------------------------------------
// Third stage. Appends codes MSB first to a 40-bit
// accumulator and writes one byte per cycle while 8 or more
// bits are held. Sums code lengths per block. A flush adds
// the RBSP stop bit and zero padding up to a byte boundary.
//------------------------------------------------------------
`include "cavlc_defs.svh"

module cavlc_bit_packer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`CAVLC_CODE_W-1:0]   code_bits_i,
	input  logic [`CAVLC_LEN_W-1:0]    code_len_i,
	input  logic                       code_we_i,
	input  logic                       code_last_i,
	input  logic                       flush_i,
	output logic                       full_o,
	output logic [7:0]                 byte_o,
	output logic                       byte_we_o,
	output logic                       block_done_o,
	output logic [`CAVLC_BITCNT_W-1:0] block_bits_o
);

	localparam int ACC_W = 40;

	logic [ACC_W-1:0]           acc_q, acc_d;   // valid bits right aligned
	logic [5:0]                 cnt_q, cnt_d;
	logic                       drain;
	logic [3:0]                 pad_len;
	logic [7:0]                 pad_bits;
	logic [`CAVLC_LEN_W-1:0]    app_len;
	logic [ACC_W-1:0]           app_bits;
	logic [ACC_W-1:0]           byte_sh;
	logic [`CAVLC_BITCNT_W-1:0] bits_q;
	logic [`CAVLC_BITCNT_W-1:0] bits_sum;
	logic [`CAVLC_BITCNT_W-1:0] block_bits_q;
	logic [7:0]                 byte_q;
	logic                       byte_we_q;
	logic                       done_q;

	assign drain    = cnt_q >= 6'd8;
	assign pad_len  = 4'd8 - {1'b0, cnt_q[2:0]};     // stop bit included
	assign pad_bits = 8'd1 << (pad_len - 4'd1);
	assign bits_sum = bits_q + `CAVLC_BITCNT_W'(code_len_i);

	// ------------------------------------------------------
	// append path, flush only when no block is in flight
	// ------------------------------------------------------
	always_comb begin
		if (code_we_i) begin
			app_len  = code_len_i;
			app_bits = ACC_W'(code_bits_i);
		end else if (flush_i) begin
			app_len  = `CAVLC_LEN_W'(pad_len);
			app_bits = ACC_W'(pad_bits);
		end else begin
			app_len  = '0;
			app_bits = '0;
		end
	end

	assign acc_d   = (acc_q << app_len) | app_bits;
	assign cnt_d   = cnt_q - (drain ? 6'd8 : 6'd0) + 6'(app_len);
	assign byte_sh = acc_q >> (cnt_q - 6'd8);   // oldest byte

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q     <= '0;
			byte_we_q <= 1'b0;
			done_q    <= 1'b0;
			bits_q    <= '0;
		end else begin
			cnt_q     <= cnt_d;
			byte_we_q <= drain;
			done_q    <= code_we_i & code_last_i;   // one cycle after last code
			if (code_we_i)
				bits_q <= code_last_i ? '0 : bits_sum;
		end
	end

	always_ff @(posedge clk) begin
		acc_q <= acc_d;
		if (drain)
			byte_q <= byte_sh[7:0];
		if (code_we_i && code_last_i)
			block_bits_q <= bits_sum;
	end

	assign full_o       = cnt_q >= 6'd16;
	assign byte_o       = byte_q;
	assign byte_we_o    = byte_we_q;
	assign block_done_o = done_q;
	assign block_bits_o = block_bits_q;

endmodule

// File: verilog/cavlc_residual_top.sv
//------------------------------------------------------------
// CAVLC residual level coder top. Block scan, level coder and
// bit packer in a chain; one block can be scanned while the
// previous one is coded.
//------------------------------------------------------------
`include "cavlc_defs.svh"

module cavlc_residual_top import cavlc_coeff_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start_i,
	input  cavlc_block_u               block_i,
	input  logic                       flush_i,
	output logic                       busy_o,
	output logic [7:0]                 byte_o,
	output logic                       byte_we_o,
	output logic                       block_done_o,
	output logic [`CAVLC_BITCNT_W-1:0] block_bits_o
);

	// scan to coder
	logic                     scan_valid;
	logic                     coder_take;
	logic [4:0]               total_coeff;
	logic [1:0]               trailing_ones;
	logic [2:0]               t1_signs;
	cavlc_block_u             level_list;

	// coder to packer
	logic [`CAVLC_CODE_W-1:0] code_bits;
	logic [`CAVLC_LEN_W-1:0]  code_len;
	logic                     code_we;
	logic                     code_last;
	logic                     packer_full;

	cavlc_block_scan cavlc_block_scan_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.start_i         (start_i),
		.block_i         (block_i),
		.take_i          (coder_take),
		.busy_o          (busy_o),
		.valid_o         (scan_valid),
		.total_coeff_o   (total_coeff),
		.trailing_ones_o (trailing_ones),
		.t1_signs_o      (t1_signs),
		.total_zeros_o   (),              // no total_zeros coder yet
		.levels_o        (level_list)
	);

	cavlc_level_coder cavlc_level_coder_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.valid_i         (scan_valid),
		.take_o          (coder_take),
		.total_coeff_i   (total_coeff),
		.trailing_ones_i (trailing_ones),
		.t1_signs_i      (t1_signs),
		.levels_i        (level_list),
		.packer_full_i   (packer_full),
		.code_bits_o     (code_bits),
		.code_len_o      (code_len),
		.code_we_o       (code_we),
		.code_last_o     (code_last)
	);

	cavlc_bit_packer cavlc_bit_packer_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.code_bits_i  (code_bits),
		.code_len_i   (code_len),
		.code_we_i    (code_we),
		.code_last_i  (code_last),
		.flush_i      (flush_i),
		.full_o       (packer_full),
		.byte_o       (byte_o),
		.byte_we_o    (byte_we_o),
		.block_done_o (block_done_o),
		.block_bits_o (block_bits_o)
	);

endmodule

// File: sim/cavlc_chk.sv
//------------------------------------------------------------
// Checker for the CAVLC residual level coder, bound to the
// top level. Compares bytes and block bit counts against the
// model in the testbench and checks start and done timing.
// Failed checks are counted in fail_cnt.
//------------------------------------------------------------
`include "cavlc_defs.svh"

module cavlc_chk (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       start_i,
	input logic                       busy_i,
	input logic                       scan_valid_i,
	input logic [7:0]                 byte_i,
	input logic                       byte_we_i,
	input logic                       block_done_i,
	input logic [`CAVLC_BITCNT_W-1:0] block_bits_i,
	input logic [7:0]                 exp_byte_i,
	input logic                       exp_byte_ok_i,
	input logic [`CAVLC_BITCNT_W-1:0] exp_bits_i,
	input logic                       exp_bits_ok_i,
	input logic                       end_chk_i,
	input int                         bytes_left_i,
	input int                         blocks_left_i
);

	int   fail_cnt;
	logic started_q;   // first start seen

	initial fail_cnt = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			started_q <= 1'b0;
		else if (start_i)
			started_q <= 1'b1;
	end

	// ------------------------------------------------------
	// control timing
	// ------------------------------------------------------
	a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!started_q |-> !busy_i && !byte_we_i && !block_done_i)
		else begin
			fail_cnt++;
			$error("ERR idle_after_reset expected 000 actual %b%b%b",
				$sampled(busy_i), $sampled(byte_we_i), $sampled(block_done_i));
		end

	a_start_accept: assert property (@(posedge clk) disable iff (!rst_n)
		start_i && !busy_i |=> busy_i)
		else begin
			fail_cnt++;
			$error("ERR start_accept expected busy 1 actual %b", $sampled(busy_i));
		end

	a_scan_latency: assert property (@(posedge clk) disable iff (!rst_n)
		start_i && !busy_i |-> ##9 scan_valid_i)
		else begin
			fail_cnt++;
			$error("ERR scan_latency expected valid 1 actual %b", $sampled(scan_valid_i));
		end

	a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		block_done_i |=> !block_done_i)
		else begin
			fail_cnt++;
			$error("block_done_o stayed high for two cycles in a row");
		end

	// ------------------------------------------------------
	// data against the model queues
	// ------------------------------------------------------
	a_byte_expected: assert property (@(posedge clk) disable iff (!rst_n)
		byte_we_i |-> exp_byte_ok_i)
		else begin
			fail_cnt++;
			$error("byte strobe while the model expects no more bytes");
		end

	a_byte_value: assert property (@(posedge clk) disable iff (!rst_n)
		byte_we_i && exp_byte_ok_i |-> byte_i == exp_byte_i)
		else begin
			fail_cnt++;
			$error("ERR byte_stream expected %02h actual %02h",
				$sampled(exp_byte_i), $sampled(byte_i));
		end

	a_bits_expected: assert property (@(posedge clk) disable iff (!rst_n)
		block_done_i |-> exp_bits_ok_i)
		else begin
			fail_cnt++;
			$error("block_done_o pulsed for a block the model never sent");
		end

	a_bits_value: assert property (@(posedge clk) disable iff (!rst_n)
		block_done_i && exp_bits_ok_i |-> block_bits_i == exp_bits_i)
		else begin
			fail_cnt++;
			$error("ERR block_bits expected %0d actual %0d",
				$sampled(exp_bits_i), $sampled(block_bits_i));
		end

	a_end_state: assert property (@(posedge clk) disable iff (!rst_n)
		end_chk_i |-> bytes_left_i == 0 && blocks_left_i == 0)
		else begin
			fail_cnt++;
			$error("ERR end_queues expected 0/0 actual %0d/%0d",
				$sampled(bytes_left_i), $sampled(blocks_left_i));
		end

endmodule

// File: sim/cavlc_tb.sv
//------------------------------------------------------------
// Testbench for the CAVLC residual level coder. Sends directed
// and random blocks, models the expected byte stream and bit
// counts, and feeds them to the bound checker. Ends with a
// flush and a summary line.
//------------------------------------------------------------
`include "cavlc_defs.svh"

module cavlc_tb import cavlc_coeff_pkg::*; ();

	localparam int DRV = 10;   // drive delay after the rising edge

	logic                       clk;
	logic                       rst_n;
	logic                       start_i;
	cavlc_block_u               block_i;
	logic                       flush_i;
	logic                       busy_o;
	logic [7:0]                 byte_o;
	logic                       byte_we_o;
	logic                       block_done_o;
	logic [`CAVLC_BITCNT_W-1:0] block_bits_o;

	// model state and queue heads seen by the checker
	bit                         model_bits[$];
	logic [7:0]                 exp_bytes[$];
	logic [`CAVLC_BITCNT_W-1:0] exp_bits[$];
	logic [7:0]                 exp_byte_head;
	logic                       exp_byte_ok;
	logic [`CAVLC_BITCNT_W-1:0] exp_bits_head;
	logic                       exp_bits_ok;
	logic                       end_chk;
	int                         bytes_left;
	int                         blocks_left;
	int                         blocks_sent;
	int                         blocks_done;
	int                         bytes_checked;

	cavlc_residual_top cavlc_residual_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_i      (start_i),
		.block_i      (block_i),
		.flush_i      (flush_i),
		.busy_o       (busy_o),
		.byte_o       (byte_o),
		.byte_we_o    (byte_we_o),
		.block_done_o (block_done_o),
		.block_bits_o (block_bits_o)
	);

	bind cavlc_residual_top cavlc_chk chk_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.start_i       (start_i),
		.busy_i        (busy_o),
		.scan_valid_i  (scan_valid),
		.byte_i        (byte_o),
		.byte_we_i     (byte_we_o),
		.block_done_i  (block_done_o),
		.block_bits_i  (block_bits_o),
		.exp_byte_i    (cavlc_tb.exp_byte_head),
		.exp_byte_ok_i (cavlc_tb.exp_byte_ok),
		.exp_bits_i    (cavlc_tb.exp_bits_head),
		.exp_bits_ok_i (cavlc_tb.exp_bits_ok),
		.end_chk_i     (cavlc_tb.end_chk),
		.bytes_left_i  (cavlc_tb.bytes_left),
		.blocks_left_i (cavlc_tb.blocks_left)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic void refresh_heads();
		exp_byte_ok   = (exp_bytes.size() > 0);
		exp_byte_head = exp_byte_ok ? exp_bytes[0] : 8'h00;
		exp_bits_ok   = (exp_bits.size() > 0);
		exp_bits_head = exp_bits_ok ? exp_bits[0] : '0;
		bytes_left    = exp_bytes.size();
		blocks_left   = exp_bits.size();
	endfunction

	// ------------------------------------------------------
	// reference model, bits MSB first into whole bytes
	// ------------------------------------------------------
	task automatic put_bits(input logic [`CAVLC_CODE_W-1:0] bits, input int len);
		logic [7:0] b;
		for (int i = len - 1; i >= 0; i--)
			model_bits.push_back(bits[i]);
		while (model_bits.size() >= 8) begin
			b = '0;
			for (int j = 0; j < 8; j++)
				b = {b[6:0], model_bits.pop_front()};
			exp_bytes.push_back(b);
		end
	endtask

	// adj for the first level after fewer than 3 T1s
	function automatic int code_for_level(input int level, input bit adj);
		int code;
		code = (level > 0) ? 2 * level - 2 : -2 * level - 1;
		if (adj)
			code -= 2;
		return code;
	endfunction

	// prefix zeros, a one, then the suffix; len is the whole code
	task automatic put_level(input int code, input int sl, output int len);
		int pfx;
		int sw;
		int sfx;
		if (sl == 0 && code < 14) begin
			pfx = code;
			sw  = 0;
			sfx = 0;
		end else if (sl == 0 && code < 30) begin
			pfx = 14;   // 4-bit suffix form
			sw  = 4;
			sfx = code - 14;
		end else if (sl == 0) begin
			pfx = 15;
			sw  = 12;
			sfx = code - 30;
		end else if ((code >> sl) < 15) begin
			pfx = code >> sl;
			sw  = sl;
			sfx = code % (1 << sl);
		end else begin
			pfx = 15;   // escape above suffix length 0
			sw  = 12;
			sfx = code - (15 << sl);
		end
		put_bits('0, pfx);
		put_bits(`CAVLC_CODE_W'(1), 1);
		put_bits(`CAVLC_CODE_W'(sfx), sw);
		len = pfx + 1 + sw;
	endtask

	// suffix length after a level of magnitude mag
	function automatic int adapt_suffix_len(input int sl, input int mag);
		int s;
		s = (sl == 0) ? 1 : sl;
		if (mag > (3 << (s - 1)) && s < `CAVLC_MAX_SUFFIX_LEN)
			s++;
		return s;
	endfunction

	task automatic model_block(input cavlc_block_u blk);
		int lv[$];
		int c;
		int t1;
		int sl;
		int len;
		int total;
		for (int k = `CAVLC_BLK_N - 1; k >= 0; k--) begin
			c = $signed(blk.coef[k]);
			if (c != 0)
				lv.push_back(c);   // reverse scan order
		end
		t1 = 0;
		while (t1 < lv.size() && t1 < `CAVLC_MAX_T1 && (lv[t1] == 1 || lv[t1] == -1))
			t1++;
		for (int i = 0; i < t1; i++)
			put_bits(`CAVLC_CODE_W'(lv[i] < 0), 1);   // sign, 1 for negative
		total = t1;
		sl = (lv.size() > 10 && t1 < `CAVLC_MAX_T1) ? 1 : 0;
		for (int i = t1; i < lv.size(); i++) begin
			put_level(code_for_level(lv[i], i == t1 && t1 < `CAVLC_MAX_T1), sl, len);
			total += len;
			sl = adapt_suffix_len(sl, (lv[i] < 0) ? -lv[i] : lv[i]);
		end
		exp_bits.push_back(`CAVLC_BITCNT_W'(total));
		refresh_heads();
	endtask

	// stop bit and zero padding
	task automatic model_flush();
		model_bits.push_back(1'b1);
		while (model_bits.size() % 8 != 0)
			model_bits.push_back(1'b0);
		put_bits('0, 0);
		refresh_heads();
	endtask

	// pop the heads as the DUT delivers
	always @(posedge clk) begin
		if (byte_we_o && exp_bytes.size() > 0) begin
			void'(exp_bytes.pop_front());
			bytes_checked++;
		end
		if (block_done_o) begin
			if (exp_bits.size() > 0)
				void'(exp_bits.pop_front());
			blocks_done++;
		end
		refresh_heads();
	end

	// ------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------
	task automatic step();
		@(posedge clk);
		#DRV;
	endtask

	task automatic send_block(input cavlc_block_u blk);
		while (busy_o)
			step();
		start_i = 1'b1;
		block_i = blk;
		model_block(blk);
		blocks_sent++;
		step();
		start_i = 1'b0;
	endtask

	// start while busy, must be ignored so not modeled
	task automatic start_while_busy(input cavlc_block_u blk);
		while (!busy_o)
			step();
		start_i = 1'b1;
		block_i = blk;
		step();
		start_i = 1'b0;
	endtask

	function automatic cavlc_block_u random_block();
		cavlc_block_u b;
		int           dens;
		int           sel;
		int           mag;
		b    = '0;
		dens = 2 + $urandom % 14;
		for (int k = 0; k < `CAVLC_BLK_N; k++) begin
			if ($urandom % 16 < dens) begin
				sel = $urandom % 8;
				if (sel < 3)
					mag = 1;
				else if (sel < 6)
					mag = 2 + $urandom % 14;
				else if (sel < 7)
					mag = 16 + $urandom % 200;
				else
					mag = 1 + $urandom % 2063;   // up to the escape limit
				b.coef[k] = ($urandom % 2) ? 16'(-mag) : 16'(mag);
			end
		end
		return b;
	endfunction

	// watchdog, limit grows with the blocks sent
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < 200 * blocks_sent + 1000) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: %0d of %0d blocks done after %0d cycles",
			blocks_done, blocks_sent, cycles);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		cavlc_block_u blk;
		int           fails;
		void'($urandom(81));
		rst_n         = 1'b0;
		start_i       = 1'b0;
		flush_i       = 1'b0;
		block_i       = '0;
		end_chk       = 1'b0;
		blocks_sent   = 0;
		blocks_done   = 0;
		bytes_checked = 0;
		refresh_heads();
		repeat (4) @(posedge clk);
		#DRV rst_n = 1'b1;
		repeat (5) step();   // idle outputs after reset

		send_block('0);      // empty block

		// trailing ones
		blk = '0;
		blk.coef[0] = 16'sd5;
		blk.coef[2] = -16'sd1;
		blk.coef[3] = 16'sd1;
		blk.coef[6] = -16'sd1;
		send_block(blk);
		blk = '0;
		blk.coef[0] = 16'sd1;
		blk.coef[1] = -16'sd1;
		send_block(blk);
		blk = '0;
		blk.coef[0] = -16'sd2;
		blk.coef[4] = 16'sd1;
		blk.coef[5] = 16'sd1;
		blk.coef[7] = 16'sd1;
		blk.coef[9] = -16'sd1;
		send_block(blk);

		// both escape forms and adaptation up to 6
		blk = '0;
		blk.coef[0] = 16'sd2063;
		blk.coef[1] = -16'sd2063;
		blk.coef[2] = 16'sd40;
		blk.coef[3] = -16'sd17;
		blk.coef[5] = 16'sd3;
		send_block(blk);
		blk = '0;
		blk.coef[1] = 16'sd20;   // escape 15 at suffix length 0
		send_block(blk);
		blk = '0;
		blk.coef[3] = 16'sd9;    // prefix 14 form
		send_block(blk);
		for (int k = 0; k < `CAVLC_BLK_N; k++)   // dense, suffix length starts at 1
			blk.coef[k] = (k % 2) ? 16'(-(k * 60 + 2)) : 16'(k * 3 + 2);
		send_block(blk);

		for (int n = 0; n < 12; n++)
			send_block(random_block());

		// ignored start, then two blocks in flight
		send_block(random_block());
		start_while_busy(random_block());
		send_block(random_block());
		send_block(random_block());

		while (blocks_done < blocks_sent)
			step();
		step();
		flush_i = 1'b1;
		model_flush();
		step();
		flush_i = 1'b0;
		while (exp_bytes.size() > 0)
			step();
		repeat (4) step();
		end_chk = 1'b1;
		step();
		end_chk = 1'b0;
		step();

		fails = cavlc_residual_top_inst.chk_inst.fail_cnt;
		$display("blocks sent %0d, blocks done %0d, bytes checked %0d, failed checks %0d",
			blocks_sent, blocks_done, bytes_checked, fails);
		if (fails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: files.f
+incdir+verilog
verilog/cavlc_coeff_pkg.sv
verilog/cavlc_code_pkg.sv
verilog/cavlc_block_scan.sv
verilog/cavlc_level_coder.sv
verilog/cavlc_bit_packer.sv
verilog/cavlc_residual_top.sv
sim/cavlc_chk.sv
sim/cavlc_tb.sv

// File: Bender.yml
package:
  name: cavlc_residual

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cavlc_coeff_pkg.sv
      - verilog/cavlc_code_pkg.sv
      - verilog/cavlc_block_scan.sv
      - verilog/cavlc_level_coder.sv
      - verilog/cavlc_bit_packer.sv
      - verilog/cavlc_residual_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/cavlc_chk.sv
      - sim/cavlc_tb.sv
